// ==== heapMemory.f ====
common/heapPkg.sv
rtl/arrayAllocator/arrayAllocator.sv
rtl/sizeTable.sv
rtl/elementStore/elementStore.sv
rtl/heapControl.sv
rtl/heapMemory.sv
test/heapMemory_assert.sv
test/heapMemoryTb.sv

// ==== test/heapMemoryTb.sv ====
/*
  Heap memory testbench. Directed allocation, bounds and stack checks, then
  LFSR-driven traffic checked against a reference model of the heap
*/
`timescale 1ns/1ps

module heapMemoryTb import heapPkg::*; ();

  localparam int cycleLimit     = 2000;             // Run needs about 750 cycles
  localparam int randomRequests = 560;

  logic        clock;
  logic        resetN;
  logic        request;
  heapRequest  requestData;
  logic        done;
  heapResponse response;

  logic [31:0] lfsrState  = 32'h2936_6cbc;
  int          cycleCount = 0;

  // ------------------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------------------
  logic        modelAllocated [arrayCount];
  int          modelStack [arrayCount];             // Freed arrays, top at modelTop-1
  int          modelTop;
  int          modelFresh;                          // Next never-used array
  int          modelSize [arrayCount];
  elementData  modelMemory [arrayCount][arrayLength];
  logic        modelKnown [arrayCount][arrayLength];  // Element written since reset

  heapMemory uut (.clock, .resetN, .request, .requestData, .done, .response);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                      // 4 ns period
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // Bound port assertions count their failures
  always @(negedge clock) begin
    if (uut.portChecks.failureCount != 0) begin
      $display("A port assertion on the DUT failed at %0t", $time);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32,22,2,1
  endfunction

  function automatic int takeBits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);              // One step per bit
      value     = (value << 1) | lfsrState[0];
    end
    return value;
  endfunction

  function automatic elementData combine(input heapAction action, input elementData value,
                                         input elementData operand);
    case (action)
      actionAdd:      return value + operand;       // Wraps at 12 bits
      actionSubtract: return value - operand;
      actionOr:       return value | operand;
      actionXor:      return value ^ operand;
      default:        return value & operand;
    endcase
  endfunction

  task automatic reportMismatch(input string message);
    $display("mismatch at %0t: %s", $time, message);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Expected response, and the model updated as the heap would be
  task automatic predict(input heapRequest r, output elementData expData,
                         output heapError expError, output logic expKnown);
    int a;
    int i;
    int s;
    a        = r.array;
    i        = r.index;
    s        = modelSize[a];
    expData  = '0;
    expError = errorNone;
    expKnown = 1'b1;
    if (r.action == actionAlloc) begin
      if (modelTop > 0) begin                       // Most recently freed first
        modelTop--;
        a = modelStack[modelTop];
      end
      else if (modelFresh < arrayCount) begin
        a = modelFresh;
        modelFresh++;
      end
      else begin
        expError = errorOutOfMemory;
        return;
      end
      modelAllocated[a] = 1'b1;
      modelSize[a]      = 0;
      expData           = elementData'(a);
    end
    else if (r.action == actionNone) begin
      expData = '0;                                 // Nothing checked
    end
    else if (!modelAllocated[a]) begin
      expError = errorNotAllocated;
    end
    else begin
      case (r.action)
        actionFree: begin
          modelAllocated[a]    = 1'b0;
          modelStack[modelTop] = a;
          modelTop++;
        end
        actionWrite: begin
          modelMemory[a][i] = r.data;
          modelKnown[a][i]  = 1'b1;
          if (i + 1 > s) modelSize[a] = i + 1;      // Grow only
          expData = r.data;
        end
        actionRead: begin
          if (i >= s) expError = errorOutOfBounds;
          else begin
            expData  = modelMemory[a][i];
            expKnown = modelKnown[a][i];
          end
        end
        actionSize: expData = elementData'(s);
        actionPush: begin
          if (s == arrayLength) expError = errorFull;
          else begin
            modelMemory[a][s] = r.data;
            modelKnown[a][s]  = 1'b1;
            modelSize[a]      = s + 1;
          end
        end
        actionPop: begin
          if (s == 0) expError = errorEmpty;
          else begin
            expData      = modelMemory[a][s-1];     // Last element
            expKnown     = modelKnown[a][s-1];
            modelSize[a] = s - 1;
          end
        end
        actionResize: begin
          if (r.data > arrayLength) expError = errorBadSize;
          else modelSize[a] = r.data;
        end
        default: begin                              // Read-modify-write group
          if (i >= s) expError = errorOutOfBounds;
          else begin
            modelMemory[a][i] = combine(r.action, modelMemory[a][i], r.data);
            expData           = modelMemory[a][i];
            expKnown          = modelKnown[a][i];
          end
        end
      endcase
    end
  endtask

  // ------------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------------
  task automatic runRequest(input heapAction action, input int array, input int index,
                            input int data);
    heapRequest r;
    elementData expData;
    heapError   expError;
    logic       expKnown;
    r.action = action;
    r.array  = arrayNumber'(array);
    r.index  = elementIndex'(index);
    r.data   = elementData'(data);
    predict(r, expData, expError, expKnown);
    request     = 1'b1;                             // Stays high on back-to-back calls
    requestData = r;
    @(negedge clock);
    if (done !== 1'b1) begin
      reportMismatch($sformatf("done is %b one cycle after %s", done, action.name()));
    end
    else if (response.error !== expError) begin
      reportMismatch($sformatf("%s on array %0d gave error %s, expected %s", action.name(),
                               array, response.error.name(), expError.name()));
    end
    else if (expKnown && response.data !== expData) begin
      reportMismatch($sformatf("%s on array %0d index %0d gave data %h, expected %h",
                               action.name(), array, index, response.data, expData));
    end
  endtask

  task automatic idle(input int cycles);
    request = 1'b0;
    repeat (cycles) begin
      @(negedge clock);
      if (done !== 1'b0) reportMismatch("done is high without a request");
    end
  endtask

  task automatic randomRequest();
    int action;
    int array;
    int data;
    action = takeBits(4);
    if (action > 13) action = 1;                    // Unused codes become writes
    array = takeBits(arrayBits);
    if (takeBits(2) != 0) begin                     // Mostly aim at live arrays
      repeat (arrayCount) begin
        if (!modelAllocated[array]) array = (array + 1) % arrayCount;
      end
    end
    data = (action == 6) ? takeBits(4) : takeBits(dataBits);  // Small resize values
    runRequest(heapAction'(action), array, takeBits(indexBits), data);
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    resetN      = 1'b0;
    request     = 1'b0;
    requestData = '0;
    modelTop    = 0;
    modelFresh  = 0;
    for (int a = 0; a < arrayCount; a++) begin
      modelAllocated[a] = 1'b0;
      modelSize[a]      = 0;
      for (int i = 0; i < arrayLength; i++) modelKnown[a][i] = 1'b0;
    end
    repeat (10) begin
      @(negedge clock);
      if (done !== 1'b0) reportMismatch("done is high during reset");
    end
    resetN = 1'b1;
    idle(2);

    for (int n = 0; n <= arrayCount; n++) runRequest(actionAlloc, 0, 0, 0);  // Ninth fails
    runRequest(actionFree, 2, 0, 0);
    runRequest(actionFree, 5, 0, 0);
    runRequest(actionRead, 2, 0, 0);                // Freed array
    runRequest(actionAlloc, 0, 0, 0);               // Gives 5
    runRequest(actionAlloc, 0, 0, 0);               // Gives 2
    idle(1);

    runRequest(actionWrite, 0, 5, 'h123);           // Size becomes 6
    runRequest(actionSize, 0, 0, 0);
    runRequest(actionRead, 0, 6, 0);
    runRequest(actionRead, 0, 5, 0);
    runRequest(actionAdd, 0, 5, 'hfff);             // Wraps
    runRequest(actionRead, 0, 5, 0);
    runRequest(actionSubtract, 0, 5, 'h200);
    runRequest(actionResize, 0, 0, 9);
    runRequest(actionResize, 0, 0, 0);
    runRequest(actionPop, 0, 0, 0);
    for (int k = 0; k <= arrayLength; k++) runRequest(actionPush, 0, 0, 'h100 + k);
    repeat (arrayLength) runRequest(actionPop, 0, 0, 0);  // Last in, first out
    idle(1);

    for (int n = 0; n < randomRequests; n++) begin
      randomRequest();
      if (takeBits(4) == 0) idle(1 + takeBits(2));  // Occasional gap
    end
    idle(2);

    if (uut.portChecks.failureCount == 0) begin
      $display("Simulation passed");
      $finish;
    end
    else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

// ==== test/heapMemory_assert.sv ====
/*
  Port assertions for the heap memory covering done timing, write echo,
  allocation error codes and zero data on errors
*/
`timescale 1ns/1ps

module heapMemoryAssert import heapPkg::*; (
  input logic        clock,
  input logic        resetN,
  input logic        request,
  input heapRequest  requestData,
  input logic        done,
  input heapResponse response
);

  int failureCount = 0;                             // Failed assertions so far

  // ------------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------------
  doneAfterRequest: assert property (@(posedge clock) disable iff (!resetN)
    request |=> done)
    else begin
      failureCount++;
      $error("done missing one cycle after a request");
    end

  noDoneWithoutRequest: assert property (@(posedge clock) disable iff (!resetN)
    !request |=> !done)
    else begin
      failureCount++;
      $error("done without a request one cycle earlier");
    end

  doneLowInReset: assert property (@(posedge clock)
    !resetN || $rose(resetN) |-> !done)
    else begin
      failureCount++;
      $error("done high during or right after reset");
    end

  // ------------------------------------------------------------------------
  // Response contents
  // ------------------------------------------------------------------------
  writeEchoesData: assert property (@(posedge clock) disable iff (!resetN)
    request && requestData.action == actionWrite |=>
      response.error != errorNone || response.data == $past(requestData.data))
    else begin
      failureCount++;
      $error("write response does not echo its data");
    end

  allocErrorCodes: assert property (@(posedge clock) disable iff (!resetN)
    request && requestData.action == actionAlloc |=>
      response.error inside {errorNone, errorOutOfMemory})
    else begin
      failureCount++;
      $error("allocation gave an unexpected error code");
    end

  errorClearsData: assert property (@(posedge clock) disable iff (!resetN)
    done && response.error != errorNone |-> response.data == '0)
    else begin
      failureCount++;
      $error("nonzero response data with an error");
    end

endmodule

bind heapMemory heapMemoryAssert portChecks (
  .clock, .resetN, .request, .requestData, .done, .response
);

// ==== rtl/heapMemory.sv ====
/*
  Heap memory top level. Joins the request decoder to the allocator,
  size table and element store; one request in, one registered response out
*/
`timescale 1ns/1ps

module heapMemory import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        request,                      // One-cycle request strobe
  input  heapRequest  requestData,
  output logic        done,                         // High one cycle after request
  output heapResponse response
);

  logic        allocated, outOfMemory;              // Allocator status
  arrayNumber  newArray;
  logic        allocateStrobe, releaseStrobe;
  arrayNumber  releaseArray;
  arraySize    size, newSize;                       // Size table
  logic        full, empty, sizeStrobe;
  arrayNumber  sizeArray;
  elementData  element, result, storeOperand;       // Element store
  logic        storeStrobe;
  elementOp    storeOp;
  arrayNumber  storeArray;
  elementIndex storeIndex;

  heapControl control (
    .clock, .resetN, .request, .requestData,
    .allocated, .newArray, .outOfMemory,
    .size, .full, .empty,
    .element, .result,
    .allocateStrobe, .releaseStrobe, .releaseArray,
    .sizeStrobe, .sizeArray, .newSize,
    .storeStrobe, .storeOp, .storeArray, .storeIndex, .storeOperand,
    .done, .response
  );

  arrayAllocator allocator (
    .clock, .resetN, .allocateStrobe, .releaseStrobe,
    .queryArray (requestData.array),                // Status of the addressed array
    .releaseArray, .allocated, .newArray, .outOfMemory
  );

  sizeTable sizes (
    .clock, .resetN, .sizeStrobe,
    .queryArray (requestData.array),
    .sizeArray, .newSize, .size, .full, .empty
  );

  elementStore store (
    .clock, .storeStrobe, .storeOp, .storeArray, .storeIndex, .storeOperand,
    .element, .result
  );

endmodule

// ==== rtl/heapControl.sv ====
/*
  Heap request decoder. Checks each request against allocation and size,
  strobes the datapath blocks and registers done and the response
*/
`timescale 1ns/1ps

module heapControl import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        request,
  input  heapRequest  requestData,
  input  logic        allocated,                    // From allocator
  input  arrayNumber  newArray,
  input  logic        outOfMemory,
  input  arraySize    size,                         // From size table
  input  logic        full,
  input  logic        empty,
  input  elementData  element,                      // From element store
  input  elementData  result,
  output logic        allocateStrobe,
  output logic        releaseStrobe,
  output arrayNumber  releaseArray,
  output logic        sizeStrobe,
  output arrayNumber  sizeArray,
  output arraySize    newSize,
  output logic        storeStrobe,
  output elementOp    storeOp,
  output arrayNumber  storeArray,
  output elementIndex storeIndex,
  output elementData  storeOperand,
  output logic        done,
  output heapResponse response
);

  arraySize    indexPlusOne;                        // Size after a write
  logic        inBounds;                            // Index below size
  heapResponse nextResponse;

  assign indexPlusOne = arraySize'(requestData.index) + arraySize'(1);
  assign inBounds     = arraySize'(requestData.index) < size;
  assign releaseArray = requestData.array;
  assign storeArray   = requestData.array;
  assign storeOperand = requestData.data;

  // ------------------------------------------------------------------------
  // Decode and check
  // ------------------------------------------------------------------------
  always_comb begin
    nextResponse   = '{data: '0, error: errorNone};
    allocateStrobe = 1'b0;
    releaseStrobe  = 1'b0;
    sizeStrobe     = 1'b0;
    sizeArray      = requestData.array;
    newSize        = size;
    storeStrobe    = 1'b0;
    storeOp        = opWrite;
    storeIndex     = requestData.index;
    if (request) begin
      if (requestData.action == actionAlloc) begin  // Only action without array check
        if (outOfMemory) nextResponse.error = errorOutOfMemory;
        else begin
          allocateStrobe    = 1'b1;
          sizeStrobe        = 1'b1;                 // New array starts empty
          sizeArray         = newArray;
          newSize           = '0;
          nextResponse.data = elementData'(newArray);
        end
      end
      else if (requestData.action != actionNone && !allocated) begin
        nextResponse.error = errorNotAllocated;     // Writable check
      end
      else begin
        case (requestData.action)
          actionFree: releaseStrobe = 1'b1;
          actionWrite: begin
            storeStrobe       = 1'b1;
            sizeStrobe        = indexPlusOne > size;  // Grow only
            newSize           = indexPlusOne;
            nextResponse.data = result;              // Operand for opWrite
          end
          actionRead: begin
            if (!inBounds) nextResponse.error = errorOutOfBounds;
            else nextResponse.data = element;
          end
          actionSize: nextResponse.data = elementData'(size);
          actionPush: begin
            if (full) nextResponse.error = errorFull;
            else begin
              storeIndex  = elementIndex'(size);     // Below 8 when not full
              storeStrobe = 1'b1;
              sizeStrobe  = 1'b1;
              newSize     = size + arraySize'(1);
            end
          end
          actionPop: begin
            if (empty) nextResponse.error = errorEmpty;
            else begin
              storeIndex        = elementIndex'(size - arraySize'(1));
              sizeStrobe        = 1'b1;
              newSize           = size - arraySize'(1);
              nextResponse.data = element;          // Last element
            end
          end
          actionResize: begin
            if (requestData.data > elementData'(arrayLength)) begin
              nextResponse.error = errorBadSize;
            end
            else begin
              sizeStrobe = 1'b1;
              newSize    = arraySize'(requestData.data);
            end
          end
          actionAdd, actionSubtract, actionOr, actionXor, actionAnd: begin
            case (requestData.action)
              actionAdd:      storeOp = opAdd;
              actionSubtract: storeOp = opSubtract;
              actionOr:       storeOp = opOr;
              actionXor:      storeOp = opXor;
              default:        storeOp = opAnd;
            endcase
            if (!inBounds) nextResponse.error = errorOutOfBounds;
            else begin
              storeStrobe       = 1'b1;             // Write back combined value
              nextResponse.data = result;
            end
          end
          default: ;                                // actionNone and unused codes
        endcase
      end
    end
  end

  // ------------------------------------------------------------------------
  // Registered response
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done     <= 1'b0;
      response <= '0;
    end
    else begin
      done <= request;
      if (request) response <= nextResponse;        // Held until next done
    end
  end

endmodule

// ==== rtl/elementStore/elementStore.sv ====
/*
  Element store. Holds every element of every array and applies the
  write or read-modify-write operation at the addressed element
*/
`timescale 1ns/1ps

module elementStore import heapPkg::*; (
  input  logic        clock,
  input  logic        storeStrobe,                  // Write result back
  input  elementOp    storeOp,
  input  arrayNumber  storeArray,
  input  elementIndex storeIndex,
  input  elementData  storeOperand,
  output elementData  element,                      // Current value
  output elementData  result                        // Value after storeOp
);

  localparam int storeDepth = arrayCount * arrayLength;

  elementData                       memory [storeDepth];  // Array-major layout
  logic [arrayBits+indexBits-1:0]   address;

  assign address = {storeArray, storeIndex};
  assign element = memory[address];

  // ------------------------------------------------------------------------
  // Operation wrapping modulo 2**dataBits
  // ------------------------------------------------------------------------
  always_comb begin
    case (storeOp)
      opAdd:      result = element + storeOperand;
      opSubtract: result = element - storeOperand;
      opOr:       result = element | storeOperand;
      opXor:      result = element ^ storeOperand;
      opAnd:      result = element & storeOperand;
      default:    result = storeOperand;            // Plain write
    endcase
  end

  always_ff @(posedge clock) begin
    if (storeStrobe) memory[address] <= result;
  end

endmodule

// ==== rtl/sizeTable.sv ====
/*
  Size table. Current size of every array, with full and empty flags for
  the array being queried
*/
`timescale 1ns/1ps

module sizeTable import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       sizeStrobe,                    // Load newSize
  input  arrayNumber queryArray,
  input  arrayNumber sizeArray,                     // Array being resized
  input  arraySize   newSize,
  output arraySize   size,
  output logic       full,
  output logic       empty
);

  arraySize sizes [arrayCount];

  assign size  = sizes[queryArray];
  assign full  = size == arraySize'(arrayLength);   // No room to push
  assign empty = size == '0;                        // Nothing to pop

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;                             // All arrays empty
      end
    end
    else if (sizeStrobe) begin
      sizes[sizeArray] <= newSize;
    end
  end

endmodule

// ==== rtl/arrayAllocator/arrayAllocator.sv ====
/*
  Array allocator. One allocation flag per array, a stack of freed arrays
  reused most recent first, and a counter of never-used arrays
*/
`timescale 1ns/1ps

module arrayAllocator import heapPkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       allocateStrobe,                // Take newArray
  input  logic       releaseStrobe,                 // Free releaseArray
  input  arrayNumber queryArray,
  input  arrayNumber releaseArray,
  output logic       allocated,
  output arrayNumber newArray,                      // Next allocation result
  output logic       outOfMemory
);

  logic [arrayCount-1:0] allocatedFlags;
  arrayNumber            freedStack [arrayCount];   // Freed arrays with top at stackTop-1
  logic [arrayBits:0]    stackTop;                  // Entries on the stack
  logic [arrayBits:0]    freshCount;                // Arrays handed out from new
  logic                  stackEmpty;

  assign stackEmpty  = stackTop == '0;
  assign allocated   = allocatedFlags[queryArray];
  assign newArray    = stackEmpty ? arrayNumber'(freshCount)
                                  : freedStack[arrayNumber'(stackTop - 1'b1)];
  assign outOfMemory = stackEmpty && freshCount == (arrayBits + 1)'(arrayCount);

  // ------------------------------------------------------------------------
  // Flags and counters
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocatedFlags <= '0;                         // Nothing allocated
      stackTop       <= '0;
      freshCount     <= '0;
    end
    else begin
      if (allocateStrobe) begin
        allocatedFlags[newArray] <= 1'b1;
        if (stackEmpty) freshCount <= freshCount + 1'b1;
        else stackTop <= stackTop - 1'b1;           // Pop reused array
      end
      else if (releaseStrobe) begin
        allocatedFlags[releaseArray] <= 1'b0;
        stackTop                     <= stackTop + 1'b1;
      end
    end
  end

  // Freed array goes onto the stack top
  always_ff @(posedge clock) begin
    if (releaseStrobe && !allocateStrobe) begin
      freedStack[arrayNumber'(stackTop)] <= releaseArray;
    end
  end

endmodule

// ==== common/heapPkg.sv ====
/*
  Heap package: sizes, word types, action and error codes, and the request
  and response structs shared by the heap control and datapath blocks
*/
package heapPkg;

  // ------------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------------
  localparam int arrayBits   = 3;                   // Bits in an array number
  localparam int indexBits   = 3;                   // Bits in an element index
  localparam int dataBits    = 12;                  // Element width
  localparam int arrayCount  = 1 << arrayBits;      // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;      // Elements per array

  typedef logic [arrayBits-1:0] arrayNumber;        // Selects one array
  typedef logic [indexBits-1:0] elementIndex;       // Selects one element
  typedef logic [dataBits-1:0]  elementData;        // One element
  typedef logic [indexBits:0]   arraySize;          // 0 to arrayLength

  // ------------------------------------------------------------------------
  // Codes
  // ------------------------------------------------------------------------
  typedef enum logic [4:0] {
    actionNone, actionWrite, actionRead, actionSize, actionPush,
    actionPop, actionResize, actionAlloc, actionFree, actionAdd,
    actionSubtract, actionOr, actionXor, actionAnd
  } heapAction;

  typedef enum logic [2:0] {
    errorNone,
    errorNotAllocated,                              // Never allocated, or freed
    errorOutOfBounds,                               // Index at or past size
    errorFull,                                      // Push onto 8 elements
    errorEmpty,                                     // Pop from 0 elements
    errorBadSize,                                   // Resize above arrayLength
    errorOutOfMemory                                // No freed or fresh array
  } heapError;

  typedef enum logic [2:0] {
    opWrite, opAdd, opSubtract, opOr, opXor, opAnd
  } elementOp;

  typedef struct packed {
    heapAction   action;
    arrayNumber  array;
    elementIndex index;
    elementData  data;                              // Operand or new size
  } heapRequest;

  typedef struct packed {
    elementData data;
    heapError   error;
  } heapResponse;

endpackage
